// File: include/exe_macros.svh
`ifndef EXE_MACROS_SVH
`define EXE_MACROS_SVH

// datapath width
`define EXE_XLEN 32

// data RAM word address width, 256 words
`define EXE_RAM_AW 8

// MIPS exception codes as carried in the cause field
`define EXC_OV   5'h0C  // arithmetic overflow
`define EXC_ADEL 5'h04  // address error on load
`define EXC_ADES 5'h05  // address error on store

`endif

// File: design/exe_pkg.sv
`default_nettype none

`include "exe_macros.svh"

package exe_pkg;

    typedef logic [`EXE_XLEN-1:0]   word_t;
    typedef logic [4:0]             reg_idx_t;
    typedef logic [4:0]             exc_code_t;
    typedef logic [3:0]             strb_t;
    typedef logic [`EXE_RAM_AW-1:0] ram_addr_t;  // word index into the data RAM

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_ADDU,
        ALU_SUB,
        ALU_SUBU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_e;

    typedef enum logic [1:0] {
        SRC2_RT,
        SRC2_ZIMM,  // zero-extended imm
        SRC2_SIMM   // sign-extended imm
    } src2_sel_e;

    typedef enum logic [3:0] {
        MEM_NONE,
        MEM_LB,
        MEM_LBU,
        MEM_LH,
        MEM_LHU,
        MEM_LW,
        MEM_SB,
        MEM_SH,
        MEM_SW,
        MEM_SWL,
        MEM_SWR
    } mem_op_e;

    // decoded instruction handed to execute, 129 bits
    typedef struct packed {
        word_t     pc;
        alu_op_e   alu_op;
        logic      src1_is_sa;  // operand 1 is imm[10:6]
        src2_sel_e src2_sel;
        mem_op_e   mem_op;
        logic      gr_we;
        reg_idx_t  dest;
        logic [15:0] imm;
        word_t     rs_value;
        word_t     rt_value;
    } ds_to_es_t;

    typedef struct packed {
        logic      wr;
        ram_addr_t addr;
        strb_t     wstrb;
        word_t     wdata;
    } mem_req_t;

    typedef struct packed {
        word_t     pc;
        mem_op_e   mem_op;
        logic      gr_we;
        reg_idx_t  dest;
        word_t     result;   // alu result, also the memory address
        logic [1:0] addr_lo;
        logic      ex;
        exc_code_t exc_code;
        word_t     rdata;    // load data from the RAM
    } es_to_ms_t;

    typedef struct packed {
        word_t     pc;
        logic      gr_we;
        reg_idx_t  dest;
        word_t     wdata;
        logic      ex;
        exc_code_t exc_code;
    } wb_t;

endpackage

`default_nettype wire

// File: design/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  exe_pkg::alu_op_e op,
    input  exe_pkg::word_t   src1,
    input  exe_pkg::word_t   src2,
    output exe_pkg::word_t   result,
    output logic             overflow
);
    import exe_pkg::*;

    word_t      sum;
    word_t      diff;
    logic [4:0] shamt;
    logic       add_ov;
    logic       sub_ov;
    logic       lt_signed;
    logic       lt_unsigned;

    assign sum   = src1 + src2;
    assign diff  = src1 - src2;
    assign shamt = src1[4:0];  // sa or rs, only low five bits count

    // operands of equal sign giving a sum of the other sign
    assign add_ov = (src1[31] == src2[31]) && (sum[31] != src1[31]);
    // operands of differing sign where the result takes the sign of src2
    assign sub_ov = (src1[31] != src2[31]) && (diff[31] != src1[31]);

    assign lt_signed   = $signed(src1) < $signed(src2);
    assign lt_unsigned = src1 < src2;

    always_comb begin
        case (op)
            ALU_ADD,
            ALU_ADDU: result = sum;
            ALU_SUB,
            ALU_SUBU: result = diff;
            ALU_AND:  result = src1 & src2;
            ALU_OR:   result = src1 | src2;
            ALU_XOR:  result = src1 ^ src2;
            ALU_NOR:  result = ~(src1 | src2);
            ALU_SLT:  result = word_t'(lt_signed);
            ALU_SLTU: result = word_t'(lt_unsigned);
            ALU_SLL:  result = src2 << shamt;
            ALU_SRL:  result = src2 >> shamt;
            ALU_SRA:  result = $signed(src2) >>> shamt;
            ALU_LUI:  result = {src2[15:0], 16'h0000};
            default:  result = '0;
        endcase
    end

    // only the trapping forms report overflow
    assign overflow = ((op == ALU_ADD) && add_ov) || ((op == ALU_SUB) && sub_ov);

endmodule

`default_nettype wire

// File: design/store_format.sv
`timescale 1ns/1ps
`default_nettype none

module store_format (
    input  exe_pkg::mem_op_e mem_op,
    input  logic [1:0]       addr_lo,
    input  exe_pkg::word_t   rt_value,
    output exe_pkg::strb_t   wstrb,
    output exe_pkg::word_t   wdata
);
    import exe_pkg::*;

    logic [4:0] lane_shift;  // 8 * addr_lo
    logic [4:0] left_shift;  // 8 * (3 - addr_lo), for swl

    assign lane_shift = {addr_lo, 3'b000};
    assign left_shift = {~addr_lo, 3'b000};

    always_comb begin
        case (mem_op)
            MEM_SB: begin
                wstrb = 4'b0001 << addr_lo;
                wdata = {4{rt_value[7:0]}};
            end
            MEM_SH: begin
                wstrb = addr_lo[1] ? 4'b1100 : 4'b0011;
                wdata = {2{rt_value[15:0]}};
            end
            MEM_SW: begin
                wstrb = 4'b1111;
                wdata = rt_value;
            end
            // swl puts the high bytes of rt at and below the address
            MEM_SWL: begin
                wstrb = 4'b1111 >> ~addr_lo;
                wdata = rt_value >> left_shift;
            end
            // swr puts the low bytes of rt at and above the address
            MEM_SWR: begin
                wstrb = 4'b1111 << addr_lo;
                wdata = rt_value << lane_shift;
            end
            default: begin
                wstrb = 4'b0000;  // loads and non-memory ops
                wdata = rt_value;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: design/exe_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "exe_macros.svh"

module exe_stage (
    input  logic               clk,
    input  logic               reset,
    input  logic               in_valid,
    output logic               in_ready,
    input  exe_pkg::ds_to_es_t in_bus,
    output logic               req_valid,
    input  logic               req_ready,
    output exe_pkg::mem_req_t  req,
    input  logic               resp_valid,
    input  exe_pkg::word_t     resp_rdata,
    output logic               es_valid,
    input  logic               ms_ready,
    output exe_pkg::es_to_ms_t es_bus
);
    import exe_pkg::*;

    logic      valid_r;
    ds_to_es_t inst_r;
    logic      sent_r;   // request for this instruction is out
    logic      done_r;   // response already held in rdata_r
    word_t     rdata_r;
    logic      accept;
    logic      ready_go;
    word_t     src1;
    word_t     src2;
    word_t     alu_result;
    logic      overflow;
    logic      is_mem;
    logic      is_store;
    logic      misalign_h;
    logic      misalign_w;
    logic      adel_ex;
    logic      ades_ex;
    logic      ex;
    exc_code_t exc_code;
    strb_t     st_strb;
    word_t     st_wdata;

    assign accept = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_r <= 1'b0;
        end else if (in_ready) begin
            valid_r <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            inst_r <= in_bus;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            sent_r <= 1'b0;
            done_r <= 1'b0;
        end else if (accept) begin
            sent_r <= 1'b0;  // fresh instruction
            done_r <= 1'b0;
        end else begin
            if (req_valid && req_ready) sent_r <= 1'b1;
            if (resp_valid) done_r <= 1'b1;
        end
    end

    // keep load data while mem stage is stalled
    always_ff @(posedge clk) begin
        if (resp_valid) begin
            rdata_r <= resp_rdata;
        end
    end

    // operand select
    assign src1 = inst_r.src1_is_sa ? {27'b0, inst_r.imm[10:6]} : inst_r.rs_value;

    always_comb begin
        case (inst_r.src2_sel)
            SRC2_ZIMM: src2 = {16'h0000, inst_r.imm};
            SRC2_SIMM: src2 = {{16{inst_r.imm[15]}}, inst_r.imm};
            default:   src2 = inst_r.rt_value;
        endcase
    end

    alu u_alu (
        .op       (inst_r.alu_op),
        .src1     (src1),
        .src2     (src2),
        .result   (alu_result),
        .overflow (overflow)
    );

    store_format u_store_format (
        .mem_op   (inst_r.mem_op),
        .addr_lo  (alu_result[1:0]),
        .rt_value (inst_r.rt_value),
        .wstrb    (st_strb),
        .wdata    (st_wdata)
    );

    assign is_mem   = inst_r.mem_op != MEM_NONE;
    assign is_store = inst_r.mem_op inside {MEM_SB, MEM_SH, MEM_SW, MEM_SWL, MEM_SWR};

    // address checks, swl/swr and byte ops never fault
    assign misalign_h = alu_result[0];
    assign misalign_w = |alu_result[1:0];
    assign adel_ex = ((inst_r.mem_op inside {MEM_LH, MEM_LHU}) && misalign_h)
                  || ((inst_r.mem_op == MEM_LW) && misalign_w);
    assign ades_ex = ((inst_r.mem_op == MEM_SH) && misalign_h)
                  || ((inst_r.mem_op == MEM_SW) && misalign_w);
    assign ex = overflow || ades_ex || adel_ex;

    always_comb begin
        if (overflow)     exc_code = `EXC_OV;
        else if (ades_ex) exc_code = `EXC_ADES;
        else if (adel_ex) exc_code = `EXC_ADEL;
        else              exc_code = '0;
    end

    // one request per memory instruction, never for a faulting one
    assign req_valid  = valid_r && is_mem && !ex && !sent_r;
    assign req.wr     = is_store;
    assign req.addr   = alu_result[`EXE_RAM_AW+1:2];
    assign req.wstrb  = st_strb;
    assign req.wdata  = st_wdata;

    assign ready_go = ex || !is_mem || resp_valid || done_r;
    assign es_valid = valid_r && ready_go;
    assign in_ready = !valid_r || (ready_go && ms_ready);

    assign es_bus.pc       = inst_r.pc;
    assign es_bus.mem_op   = inst_r.mem_op;
    assign es_bus.gr_we    = inst_r.gr_we;
    assign es_bus.dest     = inst_r.dest;
    assign es_bus.result   = alu_result;
    assign es_bus.addr_lo  = alu_result[1:0];
    assign es_bus.ex       = ex;
    assign es_bus.exc_code = exc_code;
    assign es_bus.rdata    = resp_valid ? resp_rdata : rdata_r;  // bypass on arrival

endmodule

`default_nettype wire

// File: design/data_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "exe_macros.svh"

module data_ram (
    input  logic              clk,
    input  logic              reset,
    input  logic              req_valid,
    output logic              req_ready,
    input  exe_pkg::mem_req_t req,
    output logic              resp_valid,
    output exe_pkg::word_t    resp_rdata
);
    import exe_pkg::*;

    localparam int DEPTH = 1 << `EXE_RAM_AW;

    word_t mem [DEPTH];
    logic  accept;

    assign req_ready = !resp_valid;  // one outstanding response at most
    assign accept    = req_valid && req_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= accept;  // reads and writes both answer
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) mem[i] <= '0;
        end else if (accept) begin
            resp_rdata <= mem[req.addr];
            if (req.wr) begin
                for (int b = 0; b < 4; b++) begin
                    if (req.wstrb[b]) mem[req.addr][8*b +: 8] <= req.wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: design/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
    input  logic               clk,
    input  logic               reset,
    input  logic               es_valid,
    output logic               ms_ready,
    input  exe_pkg::es_to_ms_t es_bus,
    output logic               out_valid,
    input  logic               out_ready,
    output exe_pkg::wb_t       out_bus
);
    import exe_pkg::*;

    logic        valid_r;
    es_to_ms_t   ms_r;
    logic [7:0]  load_byte;
    logic [15:0] load_half;
    word_t       wdata;

    assign ms_ready  = !valid_r || out_ready;
    assign out_valid = valid_r;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_r <= 1'b0;
        end else if (ms_ready) begin
            valid_r <= es_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (es_valid && ms_ready) begin
            ms_r <= es_bus;
        end
    end

    // little-endian lane pick
    assign load_byte = ms_r.rdata[8*ms_r.addr_lo +: 8];
    assign load_half = ms_r.addr_lo[1] ? ms_r.rdata[31:16] : ms_r.rdata[15:0];

    always_comb begin
        if (ms_r.ex) begin
            wdata = ms_r.result;  // faulting address
        end else begin
            case (ms_r.mem_op)
                MEM_LB:  wdata = {{24{load_byte[7]}}, load_byte};
                MEM_LBU: wdata = {24'h000000, load_byte};
                MEM_LH:  wdata = {{16{load_half[15]}}, load_half};
                MEM_LHU: wdata = {16'h0000, load_half};
                MEM_LW:  wdata = ms_r.rdata;
                default: wdata = ms_r.result;  // stores give the address
            endcase
        end
    end

    assign out_bus.pc       = ms_r.pc;
    assign out_bus.gr_we    = ms_r.gr_we;
    assign out_bus.dest     = ms_r.dest;
    assign out_bus.wdata    = wdata;
    assign out_bus.ex       = ms_r.ex;
    assign out_bus.exc_code = ms_r.exc_code;

endmodule

`default_nettype wire

// File: design/exe_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module exe_subsystem (
    input  logic               clk,
    input  logic               reset,
    input  logic               in_valid,
    output logic               in_ready,
    input  exe_pkg::ds_to_es_t in_bus,
    output logic               out_valid,
    input  logic               out_ready,
    output exe_pkg::wb_t       out_bus
);
    import exe_pkg::*;

    logic      req_valid;
    logic      req_ready;
    mem_req_t  req;
    logic      resp_valid;
    word_t     resp_rdata;
    logic      es_valid;
    logic      ms_ready;
    es_to_ms_t es_bus;

    exe_stage u_exe (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_bus     (in_bus),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req        (req),
        .resp_valid (resp_valid),
        .resp_rdata (resp_rdata),
        .es_valid   (es_valid),
        .ms_ready   (ms_ready),
        .es_bus     (es_bus)
    );

    data_ram u_ram (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req        (req),
        .resp_valid (resp_valid),
        .resp_rdata (resp_rdata)
    );

    mem_stage u_mem (
        .clk        (clk),
        .reset      (reset),
        .es_valid   (es_valid),
        .ms_ready   (ms_ready),
        .es_bus     (es_bus),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_bus    (out_bus)
    );

endmodule

`default_nettype wire

// File: dv/exe_sva.sv
`timescale 1ns/1ps
`default_nettype none

module exe_sva (
    input  logic               clk,
    input  logic               reset,
    input  logic               in_valid,
    input  logic               in_ready,
    input  exe_pkg::ds_to_es_t in_bus,
    input  logic               out_valid,
    input  logic               out_ready,
    input  exe_pkg::wb_t       out_bus,
    input  logic               req_valid,
    input  logic               req_ready,
    input  logic               resp_valid
);
    import exe_pkg::*;

    // producer holds valid and bus until taken
    in_stable: assert property (@(posedge clk) disable iff (reset)
        in_valid && !in_ready |=> in_valid && $stable(in_bus))
        else $error("in_valid dropped or in_bus changed before acceptance");

    out_stable: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_bus))
        else $error("out_valid dropped or out_bus changed while stalled");

    // each accepted request answered exactly once, on the next cycle
    resp_follows_req: assert property (@(posedge clk) disable iff (reset)
        req_valid && req_ready |=> resp_valid)
        else $error("accepted memory request got no response");

    resp_needs_req: assert property (@(posedge clk) disable iff (reset)
        resp_valid |-> $past(req_valid && req_ready))
        else $error("memory response without an accepted request");

    quiet_after_reset: assert property (@(posedge clk)
        reset |=> !req_valid && !out_valid)
        else $error("req_valid or out_valid high right after reset");

endmodule

bind exe_subsystem exe_sva u_sva (
    .clk        (clk),
    .reset      (reset),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_bus     (in_bus),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_bus    (out_bus),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .resp_valid (resp_valid)
);

`default_nettype wire

// File: dv/exe_checker.sv
`timescale 1ns/1ps
`default_nettype none

module exe_checker (
    input  logic         clk,
    input  logic         reset,
    input  logic         in_valid,
    input  logic         in_ready,
    input  exe_pkg::wb_t exp_bus,
    input  logic         out_valid,
    input  logic         out_ready,
    input  exe_pkg::wb_t out_bus,
    output int           checked,
    output int           value_errors,
    output int           extra_outputs,
    output int           pending
);
    import exe_pkg::*;

    wb_t want_q[$];  // expected results in issue order
    wb_t want;

    task automatic compare_field(input string name, input word_t got, input word_t expected);
        if (got !== expected) begin
            $display("[ERROR] %s got %h expected %h at pc %h", name, got, expected, want.pc);
            value_errors++;
        end
    endtask

    // mid-cycle sample, inputs and outputs settled before the transfer edge
    always @(negedge clk) begin
        if (reset) begin
            want_q.delete();
            checked       = 0;
            value_errors  = 0;
            extra_outputs = 0;
        end else begin
            if (out_valid && out_ready) begin
                if (want_q.size() == 0) begin
                    $display("unexpected output with pc %h, nothing was waiting for it",
                             out_bus.pc);
                    extra_outputs++;
                end else begin
                    want = want_q.pop_front();
                    compare_field("out_bus.pc", out_bus.pc, want.pc);
                    compare_field("out_bus.gr_we", word_t'(out_bus.gr_we), word_t'(want.gr_we));
                    compare_field("out_bus.dest", word_t'(out_bus.dest), word_t'(want.dest));
                    compare_field("out_bus.wdata", out_bus.wdata, want.wdata);
                    compare_field("out_bus.ex", word_t'(out_bus.ex), word_t'(want.ex));
                    compare_field("out_bus.exc_code", word_t'(out_bus.exc_code),
                                  word_t'(want.exc_code));
                    checked++;
                end
            end
            if (in_valid && in_ready) want_q.push_back(exp_bus);  // taken on the next edge
        end
        pending = want_q.size();
    end

endmodule

`default_nettype wire

// File: dv/exe_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "exe_macros.svh"

module exe_tb;
    import exe_pkg::*;

    localparam logic [31:0] LFSR_SEED = 32'ha9bb821b;
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;
    localparam int CYCLES_PER_ENTRY = 20;

    logic        clk;
    logic        reset;
    logic        in_valid;
    logic        in_ready;
    ds_to_es_t   in_bus;
    logic        out_valid;
    logic        out_ready;
    wb_t         out_bus;
    wb_t         exp_bus;
    logic [31:0] lfsr;
    int          cycles;
    int          checked;
    int          value_errors;
    int          extra_outputs;
    int          pending;

    // stimulus table and hand-worked results
    ds_to_es_t stim_q[$];
    wb_t       want_q[$];

    exe_subsystem i_exe_subsystem (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_bus    (in_bus),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_bus   (out_bus)
    );

    exe_checker u_checker (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .exp_bus       (exp_bus),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .out_bus       (out_bus),
        .checked       (checked),
        .value_errors  (value_errors),
        .extra_outputs (extra_outputs),
        .pending       (pending)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ LFSR_TAPS;
        end
        return state >> 1;
    endfunction

    task automatic add_entry(input alu_op_e op, input logic sa, input src2_sel_e sel,
                             input mem_op_e mop, input logic we, input logic [15:0] imm,
                             input word_t rs, input word_t rt, input word_t wdata,
                             input exc_code_t code);
        ds_to_es_t stim;
        wb_t       want;
        stim.pc         = 32'hbfc00000 + 32'(4 * stim_q.size());
        stim.alu_op     = op;
        stim.src1_is_sa = sa;
        stim.src2_sel   = sel;
        stim.mem_op     = mop;
        stim.gr_we      = we;
        stim.dest       = reg_idx_t'(stim_q.size() % 31 + 1);  // never r0
        stim.imm        = imm;
        stim.rs_value   = rs;
        stim.rt_value   = rt;
        want.pc         = stim.pc;
        want.gr_we      = we;
        want.dest       = stim.dest;
        want.wdata      = wdata;
        want.ex         = (code != 5'h0);
        want.exc_code   = code;
        stim_q.push_back(stim);
        want_q.push_back(want);
    endtask

    task automatic alu_test(input alu_op_e op, input logic sa, input src2_sel_e sel,
                            input logic [15:0] imm, input word_t rs, input word_t rt,
                            input word_t wdata, input exc_code_t code);
        add_entry(op, sa, sel, MEM_NONE, 1'b1, imm, rs, rt, wdata, code);
    endtask

    // address is rs + sign-extended imm
    task automatic mem_test(input mem_op_e mop, input word_t rs, input logic [15:0] imm,
                            input word_t rt, input word_t wdata, input exc_code_t code);
        logic is_load;
        is_load = !(mop inside {MEM_SB, MEM_SH, MEM_SW, MEM_SWL, MEM_SWR});
        add_entry(ALU_ADDU, 1'b0, SRC2_SIMM, mop, is_load, imm, rs, rt, wdata, code);
    endtask

    task automatic build_table();
        alu_test(ALU_ADD, 1'b0, SRC2_RT, 16'h0, 32'h5, 32'h7, 32'hc, 5'h0);
        alu_test(ALU_ADDU, 1'b0, SRC2_RT, 16'h0, 32'hffffffff, 32'h2, 32'h1, 5'h0);
        alu_test(ALU_SUB, 1'b0, SRC2_RT, 16'h0, 32'ha, 32'h3, 32'h7, 5'h0);
        alu_test(ALU_SUBU, 1'b0, SRC2_RT, 16'h0, 32'h3, 32'ha, 32'hfffffff9, 5'h0);
        alu_test(ALU_AND, 1'b0, SRC2_ZIMM, 16'hff00, 32'hf0f01234, 32'h0, 32'h00001200, 5'h0);
        alu_test(ALU_OR, 1'b0, SRC2_ZIMM, 16'h8001, 32'h12340000, 32'h0, 32'h12348001, 5'h0);
        alu_test(ALU_XOR, 1'b0, SRC2_RT, 16'h0, 32'hffff0000, 32'h0f0f0f0f, 32'hf0f00f0f, 5'h0);
        alu_test(ALU_NOR, 1'b0, SRC2_RT, 16'h0, 32'h0000ffff, 32'h00ff0000, 32'hff000000, 5'h0);
        alu_test(ALU_SLT, 1'b0, SRC2_SIMM, 16'h0001, 32'hfffffffe, 32'h0, 32'h1, 5'h0);
        alu_test(ALU_SLTU, 1'b0, SRC2_SIMM, 16'hffff, 32'h00010000, 32'h0, 32'h1, 5'h0);
        // sa in imm[10:6], rs ignored
        alu_test(ALU_SLL, 1'b1, SRC2_RT, 16'h0100, 32'h1f, 32'h000000ff, 32'h00000ff0, 5'h0);
        alu_test(ALU_SRL, 1'b1, SRC2_RT, 16'h0200, 32'h0, 32'h80000000, 32'h00800000, 5'h0);
        alu_test(ALU_SRA, 1'b0, SRC2_RT, 16'h0, 32'h24, 32'h80000000, 32'hf8000000, 5'h0);
        alu_test(ALU_LUI, 1'b0, SRC2_ZIMM, 16'habcd, 32'h0, 32'h0, 32'habcd0000, 5'h0);
        alu_test(ALU_ADD, 1'b0, SRC2_RT, 16'h0, 32'h7fffffff, 32'h1, 32'h80000000, `EXC_OV);
        alu_test(ALU_ADDU, 1'b0, SRC2_RT, 16'h0, 32'h7fffffff, 32'h1, 32'h80000000, 5'h0);
        alu_test(ALU_SUB, 1'b0, SRC2_RT, 16'h0, 32'h80000000, 32'h1, 32'h7fffffff, `EXC_OV);
        alu_test(ALU_SUBU, 1'b0, SRC2_RT, 16'h0, 32'h80000000, 32'h1, 32'h7fffffff, 5'h0);
        // stores build up word 0x40, then read back
        mem_test(MEM_SW, 32'h100, 16'h0, 32'h11223344, 32'h100, 5'h0);
        mem_test(MEM_SB, 32'h100, 16'h1, 32'h000000aa, 32'h101, 5'h0);
        mem_test(MEM_SH, 32'h100, 16'h2, 32'h0000beef, 32'h102, 5'h0);
        mem_test(MEM_LW, 32'h100, 16'h0, 32'h0, 32'hbeefaa44, 5'h0);
        mem_test(MEM_SWL, 32'h100, 16'h1, 32'hcafe1234, 32'h101, 5'h0);
        mem_test(MEM_SWR, 32'h100, 16'h3, 32'h55667788, 32'h103, 5'h0);
        mem_test(MEM_LW, 32'h104, 16'hfffc, 32'h0, 32'h88efcafe, 5'h0);
        mem_test(MEM_LB, 32'h100, 16'h3, 32'h0, 32'hffffff88, 5'h0);
        mem_test(MEM_LBU, 32'h100, 16'h3, 32'h0, 32'h00000088, 5'h0);
        mem_test(MEM_LBU, 32'h100, 16'h2, 32'h0, 32'h000000ef, 5'h0);
        mem_test(MEM_LH, 32'h100, 16'h2, 32'h0, 32'hffff88ef, 5'h0);
        mem_test(MEM_LHU, 32'h100, 16'h0, 32'h0, 32'h0000cafe, 5'h0);
        mem_test(MEM_LH, 32'h100, 16'h0, 32'h0, 32'hffffcafe, 5'h0);
        // misaligned, address comes back as wdata
        mem_test(MEM_LH, 32'h100, 16'h1, 32'h0, 32'h101, `EXC_ADEL);
        mem_test(MEM_LW, 32'h100, 16'h2, 32'h0, 32'h102, `EXC_ADEL);
        mem_test(MEM_SH, 32'h100, 16'h3, 32'h0000dead, 32'h103, `EXC_ADES);
        mem_test(MEM_SW, 32'h100, 16'h1, 32'hffffffff, 32'h101, `EXC_ADES);
        mem_test(MEM_LW, 32'h100, 16'h0, 32'h0, 32'h88efcafe, 5'h0);  // faulting stores left no mark
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // random back-pressure, one lfsr step per bit
    initial begin
        out_ready = 1'b0;
        lfsr      = LFSR_SEED;
        forever begin
            @(posedge clk);
            #1;
            lfsr      = lfsr_step(lfsr);
            out_ready = lfsr[0];
        end
    end

    initial begin
        int limit;
        cycles = 0;
        @(posedge clk);
        limit = stim_q.size() * CYCLES_PER_ENTRY;
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, %0d results still outstanding", cycles, pending);
        $display("Test failed");
        $finish;
    end

    initial begin
        reset    = 1'b1;
        in_valid = 1'b0;
        in_bus   = '0;
        exp_bus  = '0;
        build_table();
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int i = 0; i < stim_q.size(); i++) begin
            in_valid = 1'b1;
            in_bus   = stim_q[i];
            exp_bus  = want_q[i];
            @(negedge clk);
            while (!in_ready) @(negedge clk);
            @(posedge clk);  // accepted on this edge
            #1;
        end
        in_valid = 1'b0;
        while (pending != 0) @(posedge clk);
        repeat (4) @(posedge clk);  // room for a stray extra output
        $display("summary: %0d checked, %0d value errors, %0d extra outputs, %0d missing outputs",
                 checked, value_errors, extra_outputs, pending);
        if (value_errors + extra_outputs + pending == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+include
design/exe_pkg.sv
design/alu.sv
design/store_format.sv
design/exe_stage.sv
design/data_ram.sv
design/mem_stage.sv
design/exe_subsystem.sv
dv/exe_sva.sv
dv/exe_checker.sv
dv/exe_tb.sv

// File: Makefile
# Verilator build and run for the execute stage testbench

VERILATOR ?= verilator
TOP       ?= exe_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Test failed
PASS_MSG  ?= Test completed successfully
VFLAGS    ?= --binary --timing --assert -Wno-fatal --timescale 1ns/1ps

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "make clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
